//--- Bender.yml
package:
  name: sifh

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sifh_pkg.sv
      - hw/hist_ram.sv
      - hw/acq_sequencer.sv
      - hw/peak_finder.sv
      - hw/sifh_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/sifh_tb.sv

//--- hw/acq_sequencer.sv
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module acq_sequencer (
    input  logic              clk,
    input  logic              res,
    input  logic              sample_valid,
    output logic              sample_ready,
    input  sifh_pkg::sample_t sample,
    output logic              inc_valid,
    output sifh_pkg::addr_t   inc_addr,
    input  logic              inc_busy,
    output logic              scan_start,
    input  logic              scan_done
);

    sifh_pkg::acq_state_t state;
    sifh_pkg::acq_state_t state_nxt;

    logic [`sifh_in_cnt_w-1:0]  in_cnt;
    sifh_pkg::pixel_t           pix_cnt;
    logic [`sifh_acq_cnt_w-1:0] acq_cnt;

    logic           accept;
    logic           in_wrap;
    logic           pix_wrap;
    logic           acq_wrap;
    logic           last_sample;
    sifh_pkg::bin_t sample_bin;

    assign sample_ready = (state == sifh_pkg::idle) || (state == sifh_pkg::build_his);
    assign accept       = sample_valid & sample_ready;

    assign in_wrap     = (in_cnt == `sifh_data_num - 1);
    assign pix_wrap    = (pix_cnt == `sifh_pixels - 1);
    assign acq_wrap    = (acq_cnt == `sifh_acq_num - 1);
    assign last_sample = accept & in_wrap & pix_wrap & acq_wrap;

    // Only the coarse part of the timestamp picks the bin.
    assign sample_bin = sample[`sifh_np-1 -: `sifh_nb];

    assign inc_valid = accept;
    assign inc_addr  = {pix_cnt, sample_bin};

    // The counters wrap back to zero on the last sample of a frame.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            if (in_wrap) begin
                in_cnt <= '0;
                if (pix_wrap) begin
                    pix_cnt <= '0;
                    if (acq_wrap) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                in_cnt <= in_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            sifh_pkg::idle: begin
                if (accept) begin
                    state_nxt = sifh_pkg::build_his;
                end
            end
            sifh_pkg::build_his: begin
                if (last_sample) begin
                    state_nxt = sifh_pkg::drain;
                end
            end
            sifh_pkg::drain: begin
                if (!inc_busy) begin
                    state_nxt = sifh_pkg::find_peak;
                end
            end
            sifh_pkg::find_peak: begin
                if (scan_done) begin
                    state_nxt = sifh_pkg::idle;
                end
            end
            default: begin
                state_nxt = sifh_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= sifh_pkg::idle;
            scan_start <= 1'b0;
        end else begin
            state      <= state_nxt;
            scan_start <= (state == sifh_pkg::drain) && !inc_busy;
        end
    end

endmodule

//--- hw/hist_ram.sv
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module hist_ram (
    input  logic             clk,
    input  logic             res,
    input  logic             inc_valid,
    input  sifh_pkg::addr_t  inc_addr,
    output logic             inc_busy,
    input  logic             scan_en,
    input  sifh_pkg::addr_t  scan_addr,
    output sifh_pkg::count_t scan_count
);

    localparam int depth = 1 << `sifh_addr_w;

    sifh_pkg::count_t mem [0:depth-1];

    logic             s1_valid;
    sifh_pkg::addr_t  s1_addr;
    sifh_pkg::count_t s1_base;
    logic             s2_valid;
    sifh_pkg::addr_t  s2_addr;
    sifh_pkg::count_t s2_count;

    logic             wr_en;
    sifh_pkg::addr_t  wr_addr;
    sifh_pkg::count_t wr_data;

    // All histograms start empty; later frames rely on the scan clearing them.
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= inc_valid;
            s2_valid <= s1_valid;
        end
    end

    // If stage two still holds an update to the same bin, take its value
    // instead of the stale memory word.
    assign s1_base = (s2_valid && (s2_addr == s1_addr)) ? s2_count : mem[s1_addr];

    always_ff @(posedge clk) begin
        s1_addr  <= inc_addr;
        s2_addr  <= s1_addr;
        s2_count <= s1_base + sifh_pkg::count_t'(1);
    end

    assign inc_busy = s1_valid | s2_valid;

    // Increments and the scan never overlap, so one write port serves both.
    assign wr_en   = s2_valid | scan_en;
    assign wr_addr = s2_valid ? s2_addr : scan_addr;
    assign wr_data = s2_valid ? s2_count : '0;

    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // The scan reads the old count while the same edge clears the word.
    always_ff @(posedge clk) begin
        if (scan_en) begin
            scan_count <= mem[scan_addr];
        end
    end

endmodule

//--- hw/peak_finder.sv
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module peak_finder (
    input  logic             clk,
    input  logic             res,
    input  logic             scan_start,
    output logic             scan_done,
    output logic             scan_en,
    output sifh_pkg::addr_t  scan_addr,
    input  sifh_pkg::count_t scan_count,
    output logic             peak_valid,
    input  logic             peak_ready,
    output sifh_pkg::pixel_t peak_pixel,
    output sifh_pkg::bin_t   peak_bin,
    output sifh_pkg::count_t peak_count,
    output logic             peak_last
);

    sifh_pkg::pixel_t scan_pixel;
    sifh_pkg::bin_t   scan_bin;
    logic             rd_valid;
    sifh_pkg::bin_t   rd_bin;
    sifh_pkg::count_t best_count;
    sifh_pkg::bin_t   best_bin;
    logic             accepted;

    assign scan_addr = {scan_pixel, scan_bin};
    assign accepted  = peak_valid & peak_ready;

    // The next pixel is only scanned once the current result is taken.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scan_en    <= 1'b0;
            scan_pixel <= '0;
            scan_bin   <= '0;
        end else if (scan_start) begin
            scan_en    <= 1'b1;
            scan_pixel <= '0;
            scan_bin   <= '0;
        end else if (scan_en) begin
            scan_bin <= scan_bin + 1'b1;
            if (scan_bin == '1) begin
                scan_en <= 1'b0;
            end
        end else if (accepted && !peak_last) begin
            scan_en    <= 1'b1;
            scan_pixel <= scan_pixel + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_valid   <= 1'b0;
            peak_valid <= 1'b0;
            scan_done  <= 1'b0;
        end else begin
            rd_valid  <= scan_en;
            scan_done <= accepted & peak_last;
            if (rd_valid && (rd_bin == '1)) begin
                peak_valid <= 1'b1;
            end else if (accepted) begin
                peak_valid <= 1'b0;
            end
        end
    end

    // Bin zero seeds the maximum. A later bin must be strictly larger to win.
    always_ff @(posedge clk) begin
        rd_bin <= scan_bin;
        if (rd_valid) begin
            if ((rd_bin == '0) || (scan_count > best_count)) begin
                best_count <= scan_count;
                best_bin   <= rd_bin;
            end
        end
    end

    assign peak_pixel = scan_pixel;
    assign peak_bin   = best_bin;
    assign peak_count = best_count;
    assign peak_last  = (scan_pixel == `sifh_pixels - 1);

endmodule

//--- hw/sifh_cfg.svh
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// Raw timestamp width and the number of upper bits that select a bin.
`define sifh_np 10
`define sifh_nb 5

// Pixel layout of the incoming stream.
`define sifh_pixels 4
`define sifh_pixel_w 2

// Samples per pixel in one acquisition, and acquisitions per frame.
`define sifh_data_num 2
`define sifh_acq_num 8

// One bin can collect every sample of its pixel in a frame at most.
`define sifh_count_w $clog2(`sifh_data_num * `sifh_acq_num + 1)

// Pixel index in the upper address bits, bin index in the lower.
`define sifh_addr_w (`sifh_pixel_w + `sifh_nb)

`define sifh_bins (1 << `sifh_nb)

// Widths of the sample and acquisition counters in the sequencer.
`define sifh_in_cnt_w $clog2(`sifh_data_num)
`define sifh_acq_cnt_w $clog2(`sifh_acq_num)

`endif

//--- hw/sifh_pkg.sv
`include "sifh_cfg.svh"

package sifh_pkg;

    typedef logic [`sifh_np-1:0] sample_t;

    typedef logic [`sifh_nb-1:0] bin_t;

    typedef logic [`sifh_pixel_w-1:0] pixel_t;

    typedef logic [`sifh_count_w-1:0] count_t;

    // Pixel in the upper bits, bin in the lower bits.
    typedef logic [`sifh_addr_w-1:0] addr_t;

    typedef enum logic [1:0] {
        idle,
        build_his,
        drain,
        find_peak
    } acq_state_t;

endpackage

//--- hw/sifh_top.sv
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module sifh_top (
    input  logic              clk,
    input  logic              res,
    input  logic              sample_valid,
    output logic              sample_ready,
    input  sifh_pkg::sample_t sample,
    output logic              peak_valid,
    input  logic              peak_ready,
    output sifh_pkg::pixel_t  peak_pixel,
    output sifh_pkg::bin_t    peak_bin,
    output sifh_pkg::count_t  peak_count,
    output logic              peak_last
);

    logic             inc_valid;
    sifh_pkg::addr_t  inc_addr;
    logic             inc_busy;
    logic             scan_start;
    logic             scan_done;
    logic             scan_en;
    sifh_pkg::addr_t  scan_addr;
    sifh_pkg::count_t scan_count;

    acq_sequencer u_seq (
        .clk          (clk),
        .res          (res),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample       (sample),
        .inc_valid    (inc_valid),
        .inc_addr     (inc_addr),
        .inc_busy     (inc_busy),
        .scan_start   (scan_start),
        .scan_done    (scan_done)
    );

    hist_ram u_ram (
        .clk        (clk),
        .res        (res),
        .inc_valid  (inc_valid),
        .inc_addr   (inc_addr),
        .inc_busy   (inc_busy),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .scan_count (scan_count)
    );

    peak_finder u_peak (
        .clk        (clk),
        .res        (res),
        .scan_start (scan_start),
        .scan_done  (scan_done),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .scan_count (scan_count),
        .peak_valid (peak_valid),
        .peak_ready (peak_ready),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .peak_last  (peak_last)
    );

endmodule

//--- sources.f
+incdir+hw
hw/sifh_pkg.sv
hw/hist_ram.sv
hw/acq_sequencer.sv
hw/peak_finder.sv
hw/sifh_top.sv
tests/sifh_tb.sv

//--- tests/sifh_tb.sv
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module sifh_tb;

    localparam int clk_period = 40;
    localparam int frame_len  = `sifh_data_num * `sifh_pixels * `sifh_acq_num;
    localparam int num_frames = 5;
    // Every frame needs its samples plus one full bin scan per pixel, stretched
    // fourfold for input gaps and back-pressure.
    localparam int budget_cycles =
        num_frames * 4 * (frame_len + `sifh_pixels * (`sifh_bins + 2)) + 16 + 100;

    typedef logic [`sifh_nb+`sifh_count_w-1:0] peak_ref_t;

    logic              clk;
    logic              res;
    logic              sample_valid;
    logic              sample_ready;
    sifh_pkg::sample_t sample;
    logic              peak_valid;
    logic              peak_ready;
    sifh_pkg::pixel_t  peak_pixel;
    sifh_pkg::bin_t    peak_bin;
    sifh_pkg::count_t  peak_count;
    logic              peak_last;

    sifh_pkg::sample_t frame_s [0:frame_len-1];
    sifh_pkg::bin_t    exp_bin [0:`sifh_pixels-1];
    sifh_pkg::count_t  exp_count [0:`sifh_pixels-1];

    int               err_cnt      = 0;
    int               chk_cnt      = 0;
    int               res_total    = 0;
    int               xfer_cnt     = 0;
    logic             frame_closed = 1'b0;
    logic             rand_ready   = 1'b0;
    logic             hold_valid   = 1'b0;
    sifh_pkg::pixel_t held_pixel;
    sifh_pkg::bin_t   held_bin;
    sifh_pkg::count_t held_count;
    logic             held_last;

    sifh_top u_dut (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        chk_cnt++;
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("ERR t=%0d ns %s: expected %0d, got %0d", $time, name, exp_v, act_v);
        end
    endtask

    function automatic sifh_pkg::sample_t make_sample(input sifh_pkg::bin_t b);
        logic [`sifh_np-`sifh_nb-1:0] fine;
        fine = $urandom;
        return {b, fine};
    endfunction

    // Histogram of one pixel over the whole frame; a later bin needs a strictly
    // larger count to replace the current peak.
    function automatic peak_ref_t ref_peak(input int pix);
        int hist [0:`sifh_bins-1];
        int idx;
        int best_b;
        int best_c;
        for (int b = 0; b < `sifh_bins; b++) begin
            hist[b] = 0;
        end
        for (int a = 0; a < `sifh_acq_num; a++) begin
            for (int s = 0; s < `sifh_data_num; s++) begin
                idx = (a * `sifh_pixels + pix) * `sifh_data_num + s;
                hist[frame_s[idx][`sifh_np-1 -: `sifh_nb]]++;
            end
        end
        best_b = 0;
        best_c = hist[0];
        for (int b = 1; b < `sifh_bins; b++) begin
            if (hist[b] > best_c) begin
                best_b = b;
                best_c = hist[b];
            end
        end
        return {sifh_pkg::bin_t'(best_b), sifh_pkg::count_t'(best_c)};
    endfunction

    task automatic build_frame(input int kind);
        int p;
        sifh_pkg::bin_t b;
        for (int i = 0; i < frame_len; i++) begin
            p = (i / `sifh_data_num) % `sifh_pixels;
            case (kind)
                // Two bins share the samples evenly, the higher bin is hit first.
                1: b = ((i % `sifh_data_num) == 0) ? sifh_pkg::bin_t'(`sifh_bins - 1 - p)
                                                   : sifh_pkg::bin_t'(p + 2);
                2: b = sifh_pkg::bin_t'(7 * p + 5);
                default: b = $urandom;
            endcase
            frame_s[i] = make_sample(b);
        end
    endtask

    task automatic load_expected();
        peak_ref_t r;
        for (int p = 0; p < `sifh_pixels; p++) begin
            r            = ref_peak(p);
            exp_bin[p]   = r[`sifh_count_w +: `sifh_nb];
            exp_count[p] = r[`sifh_count_w-1:0];
        end
    endtask

    task automatic send_frame(input int gap_pct);
        int   idx;
        logic hold;
        idx = 0;
        while (idx < frame_len) begin
            @(posedge clk);
            hold = sample_valid && !sample_ready;
            if (sample_valid && sample_ready) begin
                idx++;
            end
            if (!hold) begin
                if ((idx < frame_len) && ($urandom_range(99) >= gap_pct)) begin
                    sample_valid <= 1'b1;
                    sample       <= frame_s[idx];
                end else begin
                    sample_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic run_test(input int num, input string name, input int kind,
                            input int gap_pct, input logic rnd_ready);
        int err_before;
        int target;
        err_before = err_cnt;
        target     = res_total + `sifh_pixels;
        build_frame(kind);
        load_expected();
        rand_ready <= rnd_ready;
        send_frame(gap_pct);
        wait (res_total == target);
        $display("test %0d (%s): %s, %0d mismatches", num, name,
                 (err_cnt == err_before) ? "pass" : "fail", err_cnt - err_before);
    endtask

    always @(posedge clk) begin
        peak_ready <= rand_ready ? $urandom_range(1) : 1'b1;
    end

    // Result comparison, including the hold rule under back-pressure.
    always @(posedge clk) begin
        int exp_pix;
        if (hold_valid) begin
            check_val("peak_valid (held)", 1, peak_valid);
            check_val("peak_pixel (held)", held_pixel, peak_pixel);
            check_val("peak_bin (held)", held_bin, peak_bin);
            check_val("peak_count (held)", held_count, peak_count);
            check_val("peak_last (held)", held_last, peak_last);
        end
        if (peak_valid && peak_ready) begin
            exp_pix = res_total % `sifh_pixels;
            check_val("peak_pixel", exp_pix, peak_pixel);
            check_val("peak_bin", exp_bin[exp_pix], peak_bin);
            check_val("peak_count", exp_count[exp_pix], peak_count);
            check_val("peak_last", exp_pix == `sifh_pixels - 1, peak_last);
            res_total <= res_total + 1;
        end
        hold_valid <= peak_valid && !peak_ready;
        held_pixel <= peak_pixel;
        held_bin   <= peak_bin;
        held_count <= peak_count;
        held_last  <= peak_last;
    end

    // No sample may be taken between the last transfer of a frame and the
    // acceptance of its last result.
    always @(posedge clk or negedge res) begin
        if (!res) begin
            xfer_cnt     <= 0;
            frame_closed <= 1'b0;
        end else begin
            if (frame_closed) begin
                check_val("sample_ready", 0, sample_ready);
            end
            if (sample_valid && sample_ready) begin
                if (xfer_cnt == frame_len - 1) begin
                    xfer_cnt     <= 0;
                    frame_closed <= 1'b1;
                end else begin
                    xfer_cnt <= xfer_cnt + 1;
                end
            end
            if (peak_valid && peak_ready && peak_last) begin
                frame_closed <= 1'b0;
            end
        end
    end

    initial begin
        #(budget_cycles * clk_period);
        $display("timeout: the results of the running test did not arrive in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int unsigned seed;
        seed         = $urandom(32'h5ad2);
        res          = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        peak_ready   = 1'b1;
        repeat (16) @(posedge clk);
        res <= 1'b1;
        run_test(1, "random frame", 0, 0, 1'b0);
        run_test(2, "tied bins", 1, 0, 1'b0);
        run_test(3, "single bin per pixel", 2, 0, 1'b0);
        run_test(4, "random peak_ready", 0, 0, 1'b1);
        run_test(5, "gaps on sample_valid", 0, 30, 1'b1);
        $display("summary: %0d tests, %0d checks, %0d mismatches", num_frames, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
